// File: Makefile
# Verilator build and run of the exponent/control section testbench

VERILATOR ?= verilator
TOP       ?= fpm_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  := TEST RESULT: FAIL
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/fpm_decode.sv
// opcode decoder: operation class, adder mode, qualified execute
`timescale 1ns/1ps

module fpm_decode (
	input fpm_pkg::fpm_op_t op,
	input logic pufa,
	input logic exec,
	output fpm_pkg::exp_mode_t mode,
	output logic fp_exec,
	output logic align,
	output logic cls_fp,
	output logic cls_mul,
	output logic cls_div
);
	import fpm_pkg::*;

	logic fp_code;

	// upper half of the opcode table
	assign fp_code = (op == op_af) || (op == op_sf) || (op == op_mf) || (op == op_df);

	assign cls_fp = fp_code & pufa;
	assign cls_mul = (op == op_mw) || (op == op_mf);
	assign cls_div = (op == op_dw) || (op == op_df);

	// af/sf need the alignment difference
	assign align = cls_fp & ((op == op_af) || (op == op_sf));

	// integer ops never reach the exponent path
	assign fp_exec = exec & cls_fp;

	always_comb begin
		mode = mode_pass;
		if (cls_fp) begin
			case (op)
				op_mf: begin
					mode = mode_add_b;
				end
				default: begin
					// df, af, sf all take d - b
					mode = mode_sub_b;
				end
			endcase
		end
	end

endmodule

// File: rtl/fpm_exp.sv
// exponent unit: D and B registers, operand mux, 10-bit adder
// range detection against the legal exponent limits
`timescale 1ns/1ps

module fpm_exp (
	input logic f2strob,
	input logic _0_d_,
	input logic [fpm_pkg::exp_w-1:0] w,
	input logic ld_a,
	input logic ld_b,
	input logic fp_exec,
	input logic align,
	input fpm_pkg::exp_mode_t mode,
	output logic [fpm_pkg::exp_xw-1:0] d,
	fpm_exp_if.src xo
);
	import fpm_pkg::*;

	logic [exp_xw-1:0] d_r;
	logic [exp_xw-1:0] b_r;
	logic [exp_xw-1:0] w_ext;
	logic [exp_xw-1:0] opa;
	logic [exp_xw-1:0] opb;
	logic cin;
	logic [exp_xw-1:0] sum;
	logic commit;

	// sign-extend the input bus
	assign w_ext = {{(exp_xw - exp_w){w[exp_w-1]}}, w};

	// operand select
	always_comb begin
		opa = d_r;
		opb = '0;
		cin = 1'b0;
		case (mode)
			mode_add_b: begin
				opb = b_r;
			end
			mode_sub_b: begin
				// two's complement of b
				opb = ~b_r;
				cin = 1'b1;
			end
			mode_pass: begin
				opb = '0;
			end
			mode_zero: begin
				opa = '0;
			end
			default: begin
				opb = '0;
			end
		endcase
	end

	assign sum = opa + opb + {{(exp_xw - 1){1'b0}}, cin};

	// ld_a wins over exec
	assign commit = fp_exec & ~ld_a;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			d_r <= '0;
		end else if (ld_a) begin
			d_r <= w_ext;
		end else if (fp_exec) begin
			d_r <= sum;
		end
	end

	// b copy has the lowest priority
	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			b_r <= '0;
		end else if (ld_b && !ld_a && !fp_exec) begin
			b_r <= d_r;
		end
	end

	assign d = d_r;

	assign xo.sum = sum;
	assign xo.sum_valid = commit;
	assign xo.align = align;
	assign xo.ovr = $signed(sum) > exp_max;
	assign xo.unr = $signed(sum) < exp_min;

endmodule

// File: rtl/fpm_exp_if.sv
// exponent result bundle
// exponent unit drives it, flags and shift counter read it
`timescale 1ns/1ps

interface fpm_exp_if;
	import fpm_pkg::*;

	logic [exp_xw-1:0] sum;
	logic sum_valid;
	logic align;
	logic ovr;
	logic unr;

	modport src (
		output sum, sum_valid, align, ovr, unr
	);

	// sinks commit on sum_valid, no handshake back
	modport snk (
		input sum, sum_valid, align, ovr, unr
	);

endinterface

// File: rtl/fpm_flags.sv
// condition flags: overflow, underflow, zero, sign
// registered on a committed execute, held otherwise
`timescale 1ns/1ps

module fpm_flags (
	input logic f2strob,
	input logic _0_d_,
	fpm_exp_if.snk xi,
	output logic ovf,
	output logic unf,
	output logic z_f,
	output logic m_f
);
	import fpm_pkg::*;

	logic ovf_r;
	logic unf_r;
	logic z_r;
	logic m_r;
	logic sum_zero;
	logic sum_neg;

	// taken from the pre-edge sum, same edge as d
	assign sum_zero = (xi.sum == '0);
	assign sum_neg = xi.sum[exp_xw-1];

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			ovf_r <= 1'b0;
			unf_r <= 1'b0;
		end else if (xi.sum_valid) begin
			ovf_r <= xi.ovr;
			unf_r <= xi.unr;
		end
	end

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			z_r <= 1'b0;
			m_r <= 1'b0;
		end else if (xi.sum_valid) begin
			z_r <= sum_zero;
			m_r <= sum_neg;
		end
	end

	assign ovf = ovf_r;
	assign unf = unf_r;
	assign z_f = z_r;
	assign m_f = m_r;

endmodule

// File: rtl/fpm_pkg.sv
// shared types and constants for the exponent/control section
// opcode and adder mode enums, bus widths, exponent range limits

package fpm_pkg;

	// opcode bits from the instruction register
	// the upper four are only float ops while pufa is high
	typedef enum logic [2:0] {
		op_ad = 3'd0,
		op_sd = 3'd1,
		op_mw = 3'd2,
		op_dw = 3'd3,
		op_af = 3'd4,
		op_sf = 3'd5,
		op_mf = 3'd6,
		op_df = 3'd7
	} fpm_op_t;

	// second operand of the exponent adder
	typedef enum logic [1:0] {
		mode_add_b = 2'd0,
		mode_sub_b = 2'd1,
		mode_pass  = 2'd2,
		mode_zero  = 2'd3
	} exp_mode_t;

	// input bus and extended exponent widths
	localparam int exp_w  = 8;
	localparam int exp_xw = 10;

	// legal exponent range
	localparam int exp_max = 63;
	localparam int exp_min = -64;

	// alignment shift counter
	localparam int fic_w   = 6;
	localparam int fic_max = 40;

endpackage

// File: rtl/fpm_shift_cnt.sv
// alignment shift counter
// loads |d - b| clipped to 40, counts down on step pulses
`timescale 1ns/1ps

module fpm_shift_cnt (
	input logic f2strob,
	input logic _0_d_,
	input logic step,
	fpm_exp_if.snk xi,
	output logic [fpm_pkg::fic_w-1:0] fic,
	output logic fic_zero
);
	import fpm_pkg::*;

	logic [exp_xw-1:0] mag;
	logic [fic_w-1:0] load_val;
	logic [fic_w-1:0] cnt;
	logic load;

	// magnitude of the alignment difference
	assign mag = xi.sum[exp_xw-1] ? (~xi.sum + 1'b1) : xi.sum;

	// clip, shifting further would lose the whole mantissa
	always_comb begin
		if (mag > exp_xw'(fic_max)) begin
			load_val = fic_w'(fic_max);
		end else begin
			load_val = mag[fic_w-1:0];
		end
	end

	assign load = xi.sum_valid & xi.align;

	always_ff @(posedge f2strob or negedge _0_d_) begin
		if (!_0_d_) begin
			cnt <= '0;
		end else if (load) begin
			cnt <= load_val;
		end else if (step && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign fic = cnt;
	assign fic_zero = (cnt == '0);

endmodule

// File: rtl/fpm_top.sv
// exponent/control section top: decoder, exponent unit,
// shift counter and flags on plain ports
`timescale 1ns/1ps

module fpm_top (
	input logic f2strob,
	input logic _0_d_,
	input fpm_pkg::fpm_op_t op,
	input logic pufa,
	input logic ld_a,
	input logic ld_b,
	input logic exec,
	input logic step,
	input logic [fpm_pkg::exp_w-1:0] w,
	output logic [fpm_pkg::exp_xw-1:0] d,
	output logic ovf,
	output logic unf,
	output logic z_f,
	output logic m_f,
	output logic [fpm_pkg::fic_w-1:0] fic,
	output logic fic_zero,
	output logic cls_fp,
	output logic cls_mul,
	output logic cls_div
);
	import fpm_pkg::*;

	exp_mode_t mode;
	logic fp_exec;
	logic align;

	fpm_exp_if xb ();

	fpm_decode i_decode (
		.op(op),
		.pufa(pufa),
		.exec(exec),
		.mode(mode),
		.fp_exec(fp_exec),
		.align(align),
		.cls_fp(cls_fp),
		.cls_mul(cls_mul),
		.cls_div(cls_div)
	);

	fpm_exp i_exp (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.w(w),
		.ld_a(ld_a),
		.ld_b(ld_b),
		.fp_exec(fp_exec),
		.align(align),
		.mode(mode),
		.d(d),
		.xo(xb.src)
	);

	fpm_shift_cnt i_shift_cnt (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.step(step),
		.xi(xb.snk),
		.fic(fic),
		.fic_zero(fic_zero)
	);

	fpm_flags i_flags (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.xi(xb.snk),
		.ovf(ovf),
		.unf(unf),
		.z_f(z_f),
		.m_f(m_f)
	);

endmodule

// File: src.f
rtl/fpm_pkg.sv
rtl/fpm_exp_if.sv
rtl/fpm_decode.sv
rtl/fpm_exp.sv
rtl/fpm_shift_cnt.sv
rtl/fpm_flags.sv
rtl/fpm_top.sv
tb/fpm_chk.sv
tb/fpm_tb.sv

// File: tb/fpm_chk.sv
// concurrent checks bound into the shift counter and exponent unit
`timescale 1ns/1ps

module fpm_chk #(
	parameter int w = 10,
	parameter int lim = 1023,
	parameter bit cnt_chk = 1'b1
) (
	input logic f2strob,
	input logic _0_d_,
	input logic [w-1:0] val,
	input logic upd,
	input logic is_zero
);

	// only a load or count may move the register
	a_hold: assert property (@(posedge f2strob) disable iff (!_0_d_) !upd |=> $stable(val))
		else $error("value changed without a strobe");

	// range limit and zero indication exist only on the shift counter
	if (cnt_chk) begin : g_cnt
		a_range: assert property (@(posedge f2strob) disable iff (!_0_d_) val <= lim)
			else $error("value %0d above limit %0d", val, lim);

		a_zero: assert property (@(posedge f2strob) disable iff (!_0_d_)
			is_zero == (val == '0))
			else $error("zero indication disagrees with value %0d", val);
	end

endmodule

bind fpm_shift_cnt fpm_chk #(.w(fpm_pkg::fic_w), .lim(fpm_pkg::fic_max)) i_cnt_chk (
	.f2strob(f2strob),
	._0_d_(_0_d_),
	.val(cnt),
	.upd(load | step),
	.is_zero(fic_zero)
);

bind fpm_exp fpm_chk #(.w(fpm_pkg::exp_xw), .cnt_chk(1'b0)) i_exp_chk (
	.f2strob(f2strob),
	._0_d_(_0_d_),
	.val(d_r),
	.upd(ld_a | fp_exec),
	.is_zero(1'b0)
);

// File: tb/fpm_tb.sv
// trace-driven testbench for the exponent/control section
// clock, reset, trace reader, per-test checks and summary
`timescale 1ns/1ps

module fpm_tb;
	import fpm_pkg::*;

	typedef struct {
		string name;
		int op;
		int pufa;
		int a;
		int b;
		int steps;
		int d;
		int ovf;
		int unf;
		int z;
		int m;
		int fic;
		int fz;
		int cls_fp;
		int cls_mul;
		int cls_div;
	} entry_t;

	logic f2strob;
	logic _0_d_;
	fpm_op_t op;
	logic pufa;
	logic ld_a;
	logic ld_b;
	logic exec;
	logic step;
	logic [exp_w-1:0] w;
	logic [exp_xw-1:0] d;
	logic ovf;
	logic unf;
	logic z_f;
	logic m_f;
	logic [fic_w-1:0] fic;
	logic fic_zero;
	logic cls_fp;
	logic cls_mul;
	logic cls_div;

	entry_t tests[$];
	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles = 0;
	int cycle_limit = 200;

	fpm_top i_fpm_top (
		.f2strob(f2strob),
		._0_d_(_0_d_),
		.op(op),
		.pufa(pufa),
		.ld_a(ld_a),
		.ld_b(ld_b),
		.exec(exec),
		.step(step),
		.w(w),
		.d(d),
		.ovf(ovf),
		.unf(unf),
		.z_f(z_f),
		.m_f(m_f),
		.fic(fic),
		.fic_zero(fic_zero),
		.cls_fp(cls_fp),
		.cls_mul(cls_mul),
		.cls_div(cls_div)
	);

	always #50 f2strob = ~f2strob;

	// watchdog
	always @(posedge f2strob) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	task automatic compare(input string sig, input int expv, input int actv);
		assert (expv == actv) else begin
			$display("FAIL t=%0t %s expected %0d actual %0d", $time, sig, expv, actv);
			err_cnt++;
		end
	endtask

	task automatic report(input string name, input int err_before);
		if (err_cnt == err_before) begin
			$display("test %0s: ok", name);
			pass_cnt++;
		end else begin
			$display("test %0s: %0d errors", name, err_cnt - err_before);
			fail_cnt++;
		end
	endtask

	task automatic read_trace();
		int fd;
		int cnt;
		string line;
		entry_t e;
		fd = $fopen("tb/fpm_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open trace file tb/fpm_trace.txt");
			err_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			cnt = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
				e.name, e.op, e.pufa, e.a, e.b, e.steps, e.d, e.ovf, e.unf, e.z, e.m,
				e.fic, e.fz, e.cls_fp, e.cls_mul, e.cls_div);
			if (cnt == 16) begin
				tests.push_back(e);
			end else if (cnt > 0) begin
				$display("malformed trace line: %0s", line);
				err_cnt++;
			end
		end
		$fclose(fd);
	endtask

	task automatic apply_reset();
		_0_d_ = 1'b0;
		repeat (5) @(posedge f2strob);
		@(negedge f2strob);
		_0_d_ = 1'b1;
	endtask

	task automatic check_reset();
		int err_before;
		err_before = err_cnt;
		@(negedge f2strob);
		compare("d", 0, int'($signed(d)));
		compare("ovf", 0, int'(ovf));
		compare("unf", 0, int'(unf));
		compare("z_f", 0, int'(z_f));
		compare("m_f", 0, int'(m_f));
		compare("fic", 0, int'(fic));
		compare("fic_zero", 1, int'(fic_zero));
		report("reset", err_before);
	endtask

	task automatic run_test(input entry_t e);
		int k;
		int err_before;
		err_before = err_cnt;
		// B goes in through D
		@(negedge f2strob);
		op = fpm_op_t'(e.op[2:0]);
		pufa = e.pufa[0];
		w = e.b[7:0];
		ld_a = 1'b1;
		@(negedge f2strob);
		ld_a = 1'b0;
		ld_b = 1'b1;
		@(negedge f2strob);
		ld_b = 1'b0;
		w = e.a[7:0];
		ld_a = 1'b1;
		@(negedge f2strob);
		ld_a = 1'b0;
		// D is A sign-extended
		compare("d", e.a, int'($signed(d)));
		exec = 1'b1;
		@(negedge f2strob);
		exec = 1'b0;
		compare("d", e.d, int'($signed(d)));
		compare("ovf", e.ovf, int'(ovf));
		compare("unf", e.unf, int'(unf));
		compare("z_f", e.z, int'(z_f));
		compare("m_f", e.m, int'(m_f));
		compare("cls_fp", e.cls_fp, int'(cls_fp));
		compare("cls_mul", e.cls_mul, int'(cls_mul));
		compare("cls_div", e.cls_div, int'(cls_div));
		for (k = 0; k < e.steps; k++) begin
			step = 1'b1;
			@(negedge f2strob);
		end
		step = 1'b0;
		compare("fic", e.fic, int'(fic));
		compare("fic_zero", e.fz, int'(fic_zero));
		report(e.name, err_before);
	endtask

	initial begin
		f2strob = 1'b0;
		_0_d_ = 1'b0;
		op = op_ad;
		pufa = 1'b0;
		ld_a = 1'b0;
		ld_b = 1'b0;
		exec = 1'b0;
		step = 1'b0;
		w = '0;
		read_trace();
		if (tests.size() == 0) begin
			$display("trace holds no test entries");
			err_cnt++;
		end
		// reset plus worst case per entry: four phases and a full countdown
		cycle_limit = 10 + tests.size() * (6 + fic_max) + 50;
		apply_reset();
		check_reset();
		foreach (tests[i]) begin
			run_test(tests[i]);
		end
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: tb/fpm_trace.txt
# name op pufa a b steps | d ovf unf z_f m_f fic fic_zero cls_fp cls_mul cls_div
# op 0 ad 1 sd 2 mw 3 dw 4 af 5 sf 6 mf 7 df, all values decimal, d signed
mf_small 6 1 5 3 0 8 0 0 0 0 0 1 1 1 0
mf_ovf 6 1 40 30 0 70 1 0 0 0 0 1 1 1 0
mf_neg 6 1 -20 -10 0 -30 0 0 0 1 0 1 1 1 0
mf_max 6 1 33 30 0 63 0 0 0 0 0 1 1 1 0
mf_unf 6 1 -40 -25 0 -65 0 1 0 1 0 1 1 1 0
mf_min 6 1 -32 -32 0 -64 0 0 0 1 0 1 1 1 0
mf_zero 6 1 -7 7 0 0 0 0 1 0 0 1 1 1 0
df_basic 7 1 20 5 0 15 0 0 0 0 0 1 1 0 1
df_unf 7 1 -50 30 0 -80 0 1 0 1 0 1 1 0 1
df_zero 7 1 12 12 0 0 0 0 1 0 0 1 1 0 1
df_neg 7 1 3 10 0 -7 0 0 0 1 0 1 1 0 1
df_ovf 7 1 100 -20 0 120 1 0 0 0 0 1 1 0 1
af_small 4 1 10 3 3 7 0 0 0 0 4 0 1 0 0
sf_neg 5 1 -5 20 0 -25 0 0 0 1 25 0 1 0 0
af_clip 4 1 100 -100 5 200 1 0 0 0 35 0 1 0 0
sf_full 5 1 -60 -20 40 -40 0 0 0 1 0 1 1 0 0
af_floor 4 1 2 8 9 -6 0 0 0 1 0 1 1 0 0
sf_zero 5 1 9 9 2 0 0 0 1 0 0 1 1 0 0
af_hold 4 1 100 -20 10 120 1 0 0 0 30 0 1 0 0
ad_int 0 1 7 1 0 7 1 0 0 0 30 0 0 0 0
sd_int 1 1 -3 2 0 -3 1 0 0 0 30 0 0 0 0
mw_int 2 1 11 4 0 11 1 0 0 0 30 0 0 1 0
dw_int 3 1 -8 2 0 -8 1 0 0 0 30 0 0 0 1
mf_off 6 0 40 30 0 40 1 0 0 0 30 0 0 1 0
df_off 7 0 -50 30 0 -50 1 0 0 0 30 0 0 0 1
af_off 4 0 10 50 0 10 1 0 0 0 30 0 0 0 0
sf_off 5 0 1 2 3 1 1 0 0 0 27 0 0 0 0
df_after 7 1 0 0 0 0 0 0 1 0 27 0 1 0 1
af_short 4 1 -1 1 2 -2 0 0 0 1 0 1 1 0 0
